/* project.f */
hw/vid_pkg.sv
hw/vid_win_if.sv
hw/sync_delay.sv
hw/bin_line_buffers.sv
hw/bin_morph.sv
hw/video_bin_top.sv
sim/video_bin_checker.sv
sim/video_bin_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the testbench with Verilator and runs it from the project root.

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -Wno-fatal \
    --top-module video_bin_tb \
    -f project.f \
    && ./obj_dir/Vvideo_bin_tb | tee /dev/stderr \
        | grep -qF "Test completed successfully" \
    && echo "simulation passed" \
    || { echo "simulation FAILED"; exit 1; }

/* sim/video_bin_stim.txt */
# header line: test_name mode(0 erode, 1 dilate) colour(1 spreads pixels over channels)
# then 8 rows of 16 hex grey values, one row per line
erode_block 0 0
10 00 00 00 00 00 00 00 00 00 00 00 00 00 00 7f
00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00
00 00 ff ff ff ff ff 00 00 00 00 00 00 00 00 00
00 00 ff ff ff ff ff 00 00 00 00 40 00 00 00 00
00 00 ff ff ff ff ff 00 00 00 00 00 00 00 00 00
00 00 ff ff ff ff ff 00 00 00 00 00 00 00 00 00
01 00 00 00 00 00 00 00 00 00 00 00 00 00 c0 00
00 00 00 00 00 00 80 00 00 00 00 00 00 00 00 ff
dilate_block 1 0
10 00 00 00 00 00 00 00 00 00 00 00 00 00 00 7f
00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00
00 00 ff ff ff ff ff 00 00 00 00 00 00 00 00 00
00 00 ff ff ff ff ff 00 00 00 00 40 00 00 00 00
00 00 ff ff ff ff ff 00 00 00 00 00 00 00 00 00
00 00 ff ff ff ff ff 00 00 00 00 00 00 00 00 00
01 00 00 00 00 00 00 00 00 00 00 00 00 00 c0 00
00 00 00 00 00 00 80 00 00 00 00 00 00 00 00 ff
colour_mix 0 1
00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00
00 11 22 33 44 55 66 77 88 99 aa bb cc dd ee 00
00 01 02 03 04 05 06 07 08 09 0a 0b 0c 0d 0e 00
00 f1 f2 f3 f4 f5 f6 00 f8 f9 fa fb fc fd fe 00
00 21 32 43 54 65 76 87 98 a9 ba cb dc ed fe 00
00 13 24 35 46 57 68 79 8a 9b ac 00 ce df e0 00
00 5a 5a 5a 5a 5a 5a 5a 5a 5a 5a 5a 5a 5a 5a 00
00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00

/* sim/video_bin_tb.sv */
`timescale 1ns/10ps
`default_nettype none

module video_bin_tb
    import vid_pkg::*;
();

    localparam int H_ACT       = 16;
    localparam int V_ACT       = 8;
    localparam int ROW         = 3;
    localparam int XW          = $clog2(H_ACT);
    localparam int YW          = $clog2(V_ACT);
    localparam int MAX_F       = 8;
    localparam int FRAME_SLOTS = 4 + V_ACT * (4 + H_ACT) + 4; // vsync, rows, tail.

    typedef struct packed {
        logic          hs;
        logic          vs;
        logic          de;
        logic [XW-1:0] x;
        logic [YW-1:0] y;
        logic [7:0]    pix;
        int            frm;
    } slot_t;

    logic             clk;
    logic             rstn;
    logic             i_hsync;
    logic             i_vsync;
    logic             i_de;
    logic [PIX_W-1:0] i_r;
    logic [PIX_W-1:0] i_g;
    logic [PIX_W-1:0] i_b;
    logic [XW-1:0]    i_x;
    logic [YW-1:0]    i_y;
    morph_mode_e      i_mode;
    logic             o_hsync;
    logic             o_vsync;
    logic             o_de;
    logic [PIX_W-1:0] o_r;
    logic [PIX_W-1:0] o_g;
    logic [PIX_W-1:0] o_b;
    logic [XW-1:0]    o_x;
    logic [YW-1:0]    o_y;

    string      names [MAX_F];
    logic       modes [MAX_F];
    logic       colour [MAX_F];
    logic [7:0] grey [MAX_F][V_ACT][H_ACT];
    logic       bin_map [V_ACT][H_ACT];   // binary image of the frame being sent.
    slot_t      pending [$];
    int         nf;
    int         seed        = 48431;
    int         cycle_cnt   = 0;
    int         cycle_limit = 0;

    video_bin_top #(.H_ACT(H_ACT), .V_ACT(V_ACT), .ROW(ROW)) dut0 (
        .clk     (clk),
        .rstn    (rstn),
        .i_hsync (i_hsync),
        .i_vsync (i_vsync),
        .i_de    (i_de),
        .i_r     (i_r),
        .i_g     (i_g),
        .i_b     (i_b),
        .i_x     (i_x),
        .i_y     (i_y),
        .i_mode  (i_mode),
        .o_hsync (o_hsync),
        .o_vsync (o_vsync),
        .o_de    (o_de),
        .o_r     (o_r),
        .o_g     (o_g),
        .o_b     (o_b),
        .o_x     (o_x),
        .o_y     (o_y)
    );

    initial clk = 1'b0;
    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_limit > 0 && cycle_cnt > cycle_limit) begin
            fail_run($sformatf("timeout, the run did not end within %0d cycles", cycle_limit));
        end
    end

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("Test failed");
        $fatal(1, "simulation stopped");
    endtask

    task automatic compare_value(input string tname, input string sig,
                                 input logic [31:0] exp_v, input logic [31:0] act_v);
        if (exp_v !== act_v) begin
            fail_run($sformatf("FAILED %s: %s expected %0h actual %0h",
                               tname, sig, exp_v, act_v));
        end
    endtask

    function automatic string test_name(input int frm);
        if (frm < 0) begin
            return "post_reset";
        end
        return names[frm];
    endfunction

    // a window of ROW rows ending at yi and three columns around xi.
    function automatic logic [7:0] ref_pixel(input int yi, input int xi, input logic mode);
        logic all_one;
        logic any_one;
        int   yo;
        if (yi < ROW - 1 || xi == 0 || xi == H_ACT - 1) begin
            return 8'h00;
        end
        yo      = yi - (ROW - 1);
        all_one = 1'b1;
        any_one = 1'b0;
        for (int dy = 0; dy < ROW; dy++) begin
            for (int dx = -1; dx <= 1; dx++) begin
                all_one = all_one & bin_map[yo + dy][xi + dx];
                any_one = any_one | bin_map[yo + dy][xi + dx];
            end
        end
        return (mode ? any_one : all_one) ? 8'hFF : 8'h00;
    endfunction

    task automatic load_stimulus();
        int         fd;
        int         code;
        int         sp;
        int         m;
        int         c;
        string      line;
        logic [7:0] v;
        fd = $fopen("sim/video_bin_stim.txt", "r");
        if (fd == 0) begin
            fail_run("could not open the stimulus file sim/video_bin_stim.txt");
        end
        nf = 0;
        while ($fgets(line, fd) != 0) begin
            if (line.len() < 2 || line.getc(0) == "#") begin
                continue;
            end
            if (nf == MAX_F) begin
                fail_run("the stimulus file holds more frames than the testbench can store");
            end
            sp = 0;
            while (sp < line.len() && line.getc(sp) != " ") begin
                sp++;
            end
            names[nf] = line.substr(0, sp - 1);
            code = $sscanf(line.substr(sp, line.len() - 1), "%d %d", m, c);
            if (code != 2) begin
                fail_run("a frame header in the stimulus file lacks its mode or colour flag");
            end
            modes[nf]  = m[0];
            colour[nf] = c[0];
            for (int yy = 0; yy < V_ACT; yy++) begin
                for (int xx = 0; xx < H_ACT; xx++) begin
                    code = $fscanf(fd, "%h", v);
                    if (code != 1) begin
                        fail_run("a frame in the stimulus file has too few pixel values");
                    end
                    grey[nf][yy][xx] = v;
                end
            end
            nf++;
        end
        $fclose(fd);
        if (nf == 0) begin
            fail_run("the stimulus file holds no frames");
        end
        cycle_limit = 2 * nf * FRAME_SLOTS;
    endtask

    // outputs seen now belong to the slot driven three falling edges ago.
    task automatic check_slot();
        slot_t e;
        string tn;
        e  = pending.pop_front();
        tn = test_name(e.frm);
        compare_value(tn, "o_hsync", 32'(e.hs), 32'(o_hsync));
        compare_value(tn, "o_vsync", 32'(e.vs), 32'(o_vsync));
        compare_value(tn, "o_de", 32'(e.de), 32'(o_de));
        compare_value(tn, "o_r", 32'(e.pix), 32'(o_r));
        compare_value(tn, "o_g", 32'(e.pix), 32'(o_g));
        compare_value(tn, "o_b", 32'(e.pix), 32'(o_b));
        if (e.de) begin
            compare_value(tn, "o_x", 32'(e.x), 32'(o_x));
            compare_value(tn, "o_y", 32'(e.y), 32'(o_y));
        end
    endtask

    task automatic drive_slot(input logic hs, input logic vs, input logic de,
                              input int x, input int y,
                              input logic [7:0] r, input logic [7:0] g, input logic [7:0] b,
                              input logic [7:0] exp_pix, input int frm);
        slot_t e;
        @(negedge clk);
        check_slot();
        i_hsync = hs;
        i_vsync = vs;
        i_de    = de;
        i_x     = XW'(x);
        i_y     = YW'(y);
        i_r     = r;
        i_g     = g;
        i_b     = b;
        e.hs    = hs;
        e.vs    = vs;
        e.de    = de;
        e.x     = XW'(x);
        e.y     = YW'(y - (ROW - 1)); // wraps for the blank rows.
        e.pix   = exp_pix;
        e.frm   = frm;
        pending.push_back(e);
    endtask

    task automatic idle_slot(input logic vs, input logic hs, input int y, input int frm);
        drive_slot(hs, vs, 1'b0, 0, y, 8'h00, 8'h00, 8'h00, 8'h00, frm);
    endtask

    task automatic run_frame(input int f);
        logic [7:0] v;
        logic [2:0] chans;
        logic [7:0] pr [V_ACT][H_ACT];
        logic [7:0] pg [V_ACT][H_ACT];
        logic [7:0] pb [V_ACT][H_ACT];
        for (int yy = 0; yy < V_ACT; yy++) begin
            for (int xx = 0; xx < H_ACT; xx++) begin
                v          = grey[f][yy][xx];
                pr[yy][xx] = v;
                pg[yy][xx] = v;
                pb[yy][xx] = v;
                if (colour[f] && v != 8'h00) begin
                    chans = 3'($random(seed));
                    if (chans == 3'b000) begin
                        chans = 3'b010;
                    end
                    pr[yy][xx] = chans[0] ? v : 8'h00;
                    pg[yy][xx] = chans[1] ? v : 8'h00;
                    pb[yy][xx] = chans[2] ? v : 8'h00;
                end
                bin_map[yy][xx] = (pr[yy][xx] | pg[yy][xx] | pb[yy][xx]) != 8'h00;
            end
        end
        i_mode = morph_mode_e'(modes[f]);
        repeat (2) idle_slot(1'b1, 1'b0, 0, f);
        repeat (2) idle_slot(1'b0, 1'b0, 0, f);
        for (int yy = 0; yy < V_ACT; yy++) begin
            idle_slot(1'b0, 1'b1, yy, f);  // hsync pulse starts the row.
            repeat (3) idle_slot(1'b0, 1'b0, yy, f);
            for (int xx = 0; xx < H_ACT; xx++) begin
                drive_slot(1'b0, 1'b0, 1'b1, xx, yy, pr[yy][xx], pg[yy][xx], pb[yy][xx],
                           ref_pixel(yy, xx, modes[f]), f);
            end
        end
        repeat (4) idle_slot(1'b0, 1'b0, V_ACT - 1, f);
    endtask

    initial begin
        slot_t idle_e;
        i_hsync = 1'b0;
        i_vsync = 1'b0;
        i_de    = 1'b0;
        i_r     = '0;
        i_g     = '0;
        i_b     = '0;
        i_x     = '0;
        i_y     = '0;
        i_mode  = MORPH_ERODE;
        rstn    = 1'b0;
        load_stimulus();
        repeat (2) @(negedge clk);
        rstn       = 1'b1;
        idle_e     = '0;
        idle_e.frm = -1;
        repeat (3) pending.push_back(idle_e); // the pipeline holds reset values.
        repeat (6) idle_slot(1'b0, 1'b0, 0, -1);
        for (int f = 0; f < nf; f++) begin
            run_frame(f);
        end
        repeat (3) begin
            @(negedge clk);
            check_slot();
        end
        $display("Test completed successfully");
        $finish;
    end

endmodule : video_bin_tb

`default_nettype wire

/* sim/video_bin_checker.sv */
`timescale 1ns/10ps
`default_nettype none

module video_bin_checker
    import vid_pkg::*;
(
    input wire logic             clk,
    input wire logic             rstn,
    input wire logic             i_de,
    input wire logic             o_de,
    input wire logic [PIX_W-1:0] o_r,
    input wire logic [PIX_W-1:0] o_g,
    input wire logic [PIX_W-1:0] o_b
);

    // one stage in the line buffers and two in the morphology block.
    a_de_latency : assert property (@(posedge clk) disable iff (!rstn)
        o_de == $past(i_de, 3))
        else $error("o_de does not follow i_de by three cycles");

    a_grey_out : assert property (@(posedge clk) disable iff (!rstn)
        (o_r == o_g) && (o_r == o_b))
        else $error("output channels differ");

    a_binary_out : assert property (@(posedge clk) disable iff (!rstn)
        (o_r == '0) || (o_r == '1))
        else $error("output pixel is neither black nor white");

endmodule : video_bin_checker

bind video_bin_top video_bin_checker u_checker (
    .clk  (clk),
    .rstn (rstn),
    .i_de (i_de),
    .o_de (o_de),
    .o_r  (o_r),
    .o_g  (o_g),
    .o_b  (o_b)
);

`default_nettype wire

/* hw/video_bin_top.sv */
`timescale 1ns/10ps
`default_nettype none

module video_bin_top
    import vid_pkg::*;
#(
    parameter int  H_ACT = 1280,
    parameter int  V_ACT = 720,
    parameter int  ROW   = 4,   // 3 to 5 rows in the window.
    localparam int XW    = $clog2(H_ACT),
    localparam int YW    = $clog2(V_ACT)
) (
    input  wire logic             clk,
    input  wire logic             rstn,
    input  wire logic             i_hsync,
    input  wire logic             i_vsync,
    input  wire logic             i_de,
    input  wire logic [PIX_W-1:0] i_r,
    input  wire logic [PIX_W-1:0] i_g,
    input  wire logic [PIX_W-1:0] i_b,
    input  wire logic [XW-1:0]    i_x,
    input  wire logic [YW-1:0]    i_y,
    input  wire morph_mode_e      i_mode,
    output logic                  o_hsync,
    output logic                  o_vsync,
    output logic                  o_de,
    output logic [PIX_W-1:0]      o_r,
    output logic [PIX_W-1:0]      o_g,
    output logic [PIX_W-1:0]      o_b,
    output logic [XW-1:0]         o_x,
    output logic [YW-1:0]         o_y
);

    vid_ctrl_t in_ctrl;
    vid_ctrl_t out_ctrl;

    assign in_ctrl.hsync = i_hsync;
    assign in_ctrl.vsync = i_vsync;
    assign in_ctrl.de    = i_de;

    vid_win_if #(.H_ACT(H_ACT), .V_ACT(V_ACT), .ROW(ROW)) u_win ();

    bin_line_buffers #(.H_ACT(H_ACT), .V_ACT(V_ACT), .ROW(ROW)) u_line_buf (
        .clk    (clk),
        .rstn   (rstn),
        .i_ctrl (in_ctrl),
        .i_r    (i_r),
        .i_g    (i_g),
        .i_b    (i_b),
        .i_x    (i_x),
        .i_y    (i_y),
        .o_win  (u_win.src)
    );

    bin_morph #(.H_ACT(H_ACT), .V_ACT(V_ACT), .ROW(ROW)) u_morph (
        .clk    (clk),
        .rstn   (rstn),
        .i_win  (u_win.snk),
        .i_mode (i_mode),
        .o_ctrl (out_ctrl),
        .o_r    (o_r),
        .o_g    (o_g),
        .o_b    (o_b),
        .o_x    (o_x),
        .o_y    (o_y)
    );

    assign o_hsync = out_ctrl.hsync;
    assign o_vsync = out_ctrl.vsync;
    assign o_de    = out_ctrl.de;

endmodule : video_bin_top

`default_nettype wire

/* hw/bin_morph.sv */
`timescale 1ns/10ps
`default_nettype none

module bin_morph
    import vid_pkg::*;
#(
    parameter int  H_ACT = 1280,
    parameter int  V_ACT = 720,
    parameter int  ROW   = 4,
    localparam int XW    = $clog2(H_ACT),
    localparam int YW    = $clog2(V_ACT)
) (
    input  wire logic         clk,
    input  wire logic         rstn,
    vid_win_if.snk            i_win,
    input  wire morph_mode_e  i_mode,
    output vid_ctrl_t         o_ctrl,
    output logic [PIX_W-1:0]  o_r,
    output logic [PIX_W-1:0]  o_g,
    output logic [PIX_W-1:0]  o_b,
    output logic [XW-1:0]     o_x,
    output logic [YW-1:0]     o_y
);

    typedef struct packed {
        logic [XW-1:0] x;
        logic [YW-1:0] y;
    } coord_t;

    logic       col_val;
    logic [1:0] col_q;
    logic [2:0] nbr;
    logic       mask;
    logic       mask_q;
    logic       pix_val;
    logic       pix_q;
    coord_t     coord_in;
    coord_t     coord_d;

    always_comb begin
        col_val = 1'b0;
        case (i_mode)
            MORPH_ERODE:  col_val = &i_win.window;
            MORPH_DILATE: col_val = |i_win.window;
            default:      col_val = 1'b0;
        endcase
    end

    // columns x+1, x and x-1 around the pixel being decided.
    assign nbr = {col_val, col_q};

    always_comb begin
        pix_val = 1'b0;
        case (i_mode)
            MORPH_ERODE:  pix_val = &nbr;
            MORPH_DILATE: pix_val = |nbr;
            default:      pix_val = 1'b0;
        endcase
    end

    assign mask = !i_win.ctrl.de || i_win.blank ||
                  i_win.x == '0 || i_win.x == XW'(H_ACT-1); // no full neighbourhood here.

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            col_q  <= '0;
            mask_q <= 1'b1;
            pix_q  <= 1'b0;
        end else begin
            col_q  <= {col_val, col_q[1]};
            mask_q <= mask;
            pix_q  <= pix_val & ~mask_q;
        end
    end

    assign coord_in.x = i_win.x;
    assign coord_in.y = i_win.y;

    sync_delay #(
        .DELAY (2),
        .T     (vid_ctrl_t)
    ) u_ctrl_dly (
        .clk    (clk),
        .rstn   (rstn),
        .i_data (i_win.ctrl),
        .o_data (o_ctrl)
    );

    sync_delay #(
        .DELAY (2),
        .T     (coord_t)
    ) u_coord_dly (
        .clk    (clk),
        .rstn   (rstn),
        .i_data (coord_in),
        .o_data (coord_d)
    );

    assign o_r = {PIX_W{pix_q}};
    assign o_g = {PIX_W{pix_q}};
    assign o_b = {PIX_W{pix_q}};
    assign o_x = coord_d.x;
    assign o_y = coord_d.y;

endmodule : bin_morph

`default_nettype wire

/* hw/bin_line_buffers.sv */
`timescale 1ns/10ps
`default_nettype none

module bin_line_buffers
    import vid_pkg::*;
#(
    parameter int  H_ACT = 1280,
    parameter int  V_ACT = 720,
    parameter int  ROW   = 4,
    localparam int XW    = $clog2(H_ACT),
    localparam int YW    = $clog2(V_ACT),
    localparam int PW    = $clog2(ROW)
) (
    input  wire logic             clk,
    input  wire logic             rstn,
    input  wire vid_ctrl_t        i_ctrl,
    input  wire logic [PIX_W-1:0] i_r,
    input  wire logic [PIX_W-1:0] i_g,
    input  wire logic [PIX_W-1:0] i_b,
    input  wire logic [XW-1:0]    i_x,
    input  wire logic [YW-1:0]    i_y,
    vid_win_if.src                o_win
);

    typedef struct packed {
        logic [XW-1:0] x;
        logic [YW-1:0] y;
    } coord_t;

    logic           bin;
    logic           hsync_q;
    logic           hs_rise;
    logic [XW-1:0]  addr;
    logic [PW-1:0]  ptr;
    logic [PW-1:0]  rd_ptr;
    logic [ROW-1:0] rd_bits;
    logic           cur_bit;
    logic [ROW-1:0] win;
    coord_t         coord_in;
    coord_t         coord_d;

    assign bin     = |{i_r, i_g, i_b}; // only pure black counts as background.
    assign hs_rise = i_ctrl.hsync & ~hsync_q;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            hsync_q <= 1'b0;
        end else begin
            hsync_q <= i_ctrl.hsync;
        end
    end

    // ptr names the line memory that takes the incoming row.
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            addr <= '0;
            ptr  <= '0;
        end else if (i_ctrl.vsync) begin
            addr <= '0;
            ptr  <= '0;
        end else if (hs_rise) begin
            addr <= '0;
            if (ptr == PW'(ROW-1)) begin
                ptr <= '0;
            end else begin
                ptr <= ptr + 1'b1;
            end
        end else if (i_ctrl.de && addr != XW'(H_ACT-1)) begin
            addr <= addr + 1'b1;
        end
    end

    for (genvar i = 0; i < ROW; i++) begin : g_row
        logic [H_ACT-1:0] mem;
        logic             rd_bit;

        always_ff @(posedge clk) begin
            if (ptr == PW'(i) && i_ctrl.de) begin
                mem[addr] <= bin;
            end
            rd_bit <= mem[addr]; // the row being written is replaced by cur_bit.
        end

        assign rd_bits[i] = rd_bit;
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            cur_bit <= 1'b0;
            rd_ptr  <= '0;
        end else begin
            cur_bit <= bin;
            rd_ptr  <= ptr; // keeps the rotation aligned with the read data.
        end
    end

    // memory ptr+1 holds the oldest row, ptr-1 the previous one.
    always_comb begin
        win = '0;
        for (int j = 0; j < ROW-1; j++) begin
            win[j] = rd_bits[(int'(rd_ptr) + 1 + j) % ROW];
        end
        win[ROW-1] = cur_bit;
    end

    assign o_win.window = win;

    assign coord_in.x = i_x;
    assign coord_in.y = i_y;

    sync_delay #(
        .DELAY (1),
        .T     (vid_ctrl_t)
    ) u_ctrl_dly (
        .clk    (clk),
        .rstn   (rstn),
        .i_data (i_ctrl),
        .o_data (o_win.ctrl)
    );

    sync_delay #(
        .DELAY (1),
        .T     (coord_t)
    ) u_coord_dly (
        .clk    (clk),
        .rstn   (rstn),
        .i_data (coord_in),
        .o_data (coord_d)
    );

    assign o_win.x     = coord_d.x;
    assign o_win.blank = coord_d.y < YW'(ROW-1);
    assign o_win.y     = coord_d.y - YW'(ROW-1);

endmodule : bin_line_buffers

`default_nettype wire

/* hw/sync_delay.sv */
`timescale 1ns/10ps
`default_nettype none

module sync_delay
    import vid_pkg::*;
#(
    parameter int  DELAY = 1,
    parameter type T     = vid_ctrl_t
) (
    input  wire logic clk,
    input  wire logic rstn,
    input  wire T     i_data,
    output T          o_data
);

    T stage [DELAY];

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            for (int i = 0; i < DELAY; i++) begin
                stage[i] <= '0;
            end
        end else begin
            stage[0] <= i_data;
            for (int i = 1; i < DELAY; i++) begin
                stage[i] <= stage[i-1];
            end
        end
    end

    assign o_data = stage[DELAY-1];

endmodule : sync_delay

`default_nettype wire

/* hw/vid_win_if.sv */
`timescale 1ns/10ps
`default_nettype none

interface vid_win_if
    import vid_pkg::*;
#(
    parameter int  H_ACT = 1280,
    parameter int  V_ACT = 720,
    parameter int  ROW   = 4,
    localparam int XW    = $clog2(H_ACT),
    localparam int YW    = $clog2(V_ACT)
) ();

    vid_ctrl_t      ctrl;
    logic [XW-1:0]  x;
    logic [YW-1:0]  y;      // row of the oldest line in the window.
    logic           blank;  // window not yet filled with this frame's rows.
    logic [ROW-1:0] window; // msb is the current row, lsb the oldest.

    modport src (
        output ctrl, x, y, blank, window
    );

    modport snk (
        input ctrl, x, y, blank, window
    );

endinterface : vid_win_if

`default_nettype wire

/* hw/vid_pkg.sv */
`default_nettype none

package vid_pkg;

    parameter int PIX_W = 8; // bits per colour channel.

    // sync and enable travel together through every pipeline stage.
    typedef struct packed {
        logic hsync;
        logic vsync;
        logic de;
    } vid_ctrl_t;

    // erosion keeps a pixel only when its whole neighbourhood is set.
    typedef enum logic {
        MORPH_ERODE  = 1'b0,
        MORPH_DILATE = 1'b1
    } morph_mode_e;

endpackage : vid_pkg

`default_nettype wire
